/* build.f */
source/routerPkg.sv
source/grantTimer.sv
source/portArbiter.sv
source/outputMux.sv
source/routerOutPort.sv
bench/clockGen.sv
bench/routerOutPortTb.sv

/* run.sh */
#!/bin/sh
# compile and run the router output port testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module routerOutPortTb -f build.f -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if echo "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1

/* bench/routerOutPortTb.sv */
`timescale 1ns/1ps

module routerOutPortTb;
  import routerPkg::*;

  localparam int resetCycles = 10;
  localparam int randomCycles = 400;
  localparam int totalCycles = resetCycles + 4 + 24 + 17 + 12 + randomCycles + 3 + 2;
  localparam int timeoutCycles = 2 * totalCycles;

  typedef struct packed {
    logic [4:0] grant;
    logic [4:0][11:0] limit;
    logic [4:0][11:0] count;
    logic outValid;
    logic [2:0] outType;
    logic [15:0] outData;
    logic [2:0] outSource;
  } refState;

  logic clk;
  logic rst;
  logic [numPorts-1:0] req = '0;
  logic [4:0][2:0] stimType = '0;
  logic [4:0][15:0] stimData = '0;
  flitKind flitType [numPorts];
  logic [15:0] flitData [numPorts];
  logic [numPorts-1:0] grant;
  logic outValid;
  flitKind outType;
  logic [15:0] outData;
  portIdx outSource;
  refState model = '0;
  logic [15:0] lfsr = 16'd51977;
  logic failed = 1'b0;
  int cycleCount = 0;

  clockGen #(.periodNs(20), .resetCycles(resetCycles)) clockGen_i (.clk(clk), .rst(rst));

  for (genvar p = 0; p < numPorts; p++)
  begin : gDrive
    assign flitType[p] = flitKind'(stimType[p]);
    assign flitData[p] = stimData[p];
  end

  routerOutPort #(.dataWidth(16)) routerOutPort_i (
    .clk(clk),
    .rst(rst),
    .req(req),
    .flitType(flitType),
    .flitData(flitData),
    .grant(grant),
    .outValid(outValid),
    .outType(outType),
    .outData(outData),
    .outSource(outSource)
  );

  // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic drawBits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  // one clock of the arbiter, the five timers and the output register.
  function automatic refState modelStep(input refState s, input logic [4:0] r,
      input logic [4:0][2:0] t, input logic [4:0][15:0] d);
    refState n;
    logic [4:0] run;
    logic found;
    int h;
    int q;
    n = s;
    run = '0;
    found = 1'b0;
    h = -1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (s.grant[p])
        h = p;
    end
    n.grant = '0;
    if (h >= 0 && r[h] && s.count[h] != s.limit[h])
    begin
      n.grant[h] = 1'b1;  // holder keeps the link.
      run[h] = 1'b1;
    end
    else
    begin
      for (int k = 0; k < numPorts; k++)
      begin
        q = (h < 0) ? k : (h + 1 + k) % numPorts;
        if (!found && r[q] && q != h)
        begin
          n.grant[q] = 1'b1;
          found = 1'b1;
        end
      end
    end
    for (int p = 0; p < numPorts; p++)
    begin
      if (t[p] == 3'd1)
        n.limit[p] = d[p][11:0];  // header carries the length.
      n.count[p] = run[p] ? s.count[p] + 12'd1 : 12'd0;
    end
    n.outValid = 1'b0;
    if (h >= 0)
    begin
      if (r[h])
      begin
        n.outValid = 1'b1;
        n.outType = t[h];
        n.outData = d[h];
        n.outSource = 3'(h);
      end
    end
    return n;
  endfunction

  task automatic compareValue(input string name, input logic [15:0] actual,
      input logic [15:0] expected);
    if (actual !== expected)
    begin
      failed = 1'b1;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  always @(posedge clk)
  begin
    if (rst)
      model = '0;
    else
    begin
      compareValue("grant", 16'(grant), 16'(model.grant));
      compareValue("outValid", 16'(outValid), 16'(model.outValid));
      compareValue("outType", 16'(outType), 16'(model.outType));
      compareValue("outData", outData, model.outData);
      compareValue("outSource", 16'(outSource), 16'(model.outSource));
      model = modelStep(model, req, stimType, stimData);
    end
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      $display("timeout: the stimulus did not finish within %0d cycles", timeoutCycles);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  task automatic applyCycle(input logic [4:0] r, input logic [4:0][2:0] t,
      input logic [4:0][15:0] d);
    @(posedge clk);
    req <= r;
    stimType <= t;
    stimData <= d;
  endtask

  // headers take their length word, other requesters send body flits.
  task automatic driveFlits(input logic [4:0] r, input logic [4:0] isHead,
      input logic [4:0][11:0] lens, input logic [3:0] tag);
    logic [4:0][2:0] t;
    logic [4:0][15:0] d;
    for (int p = 0; p < numPorts; p++)
    begin
      t[p] = isHead[p] ? 3'd1 : (r[p] ? 3'd2 : 3'd0);
      d[p] = isHead[p] ? {tag, lens[p]} : {tag, 9'h0, 3'(p)};
    end
    applyCycle(r, t, d);
  endtask

  task automatic randomTraffic(input int cycles);
    logic [4:0] r;
    logic [4:0][2:0] t;
    logic [4:0][15:0] d;
    logic [15:0] v;
    for (int c = 0; c < cycles; c++)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        drawBits(2, v);
        r[p] = (v[1:0] != 2'd0);  // requests three times in four.
        drawBits(2, v);
        t[p] = {1'b0, v[1:0]};
        drawBits(16, v);
        d[p] = v;
        if (t[p] == 3'd1)
        begin
          drawBits(3, v);
          d[p][11:0] = 12'(v[2:0]);
        end
      end
      applyCycle(r, t, d);
    end
  endtask

  initial
  begin
    logic [4:0][11:0] lens;
    wait (!rst);
    repeat (4) driveFlits('0, '0, '0, 4'h0);
    lens = {12'd4, 12'd1, 12'd3, 12'd0, 12'd2};  // S W E N L.
    driveFlits(5'b11111, 5'b11111, lens, 4'h1);
    repeat (20) driveFlits(5'b11111, 5'b00000, lens, 4'h2);
    repeat (3) driveFlits('0, '0, '0, 4'h0);
    lens = '0;
    lens[NORTH] = 12'd3;
    driveFlits(5'b00010, 5'b00010, lens, 4'h3);
    repeat (6) driveFlits(5'b00010, 5'b00000, lens, 4'h3);
    lens[NORTH] = 12'd5;  // lands mid-hold.
    driveFlits(5'b00010, 5'b00010, lens, 4'h4);
    repeat (6) driveFlits(5'b00010, 5'b00000, lens, 4'h4);
    repeat (3) driveFlits('0, '0, '0, 4'h0);
    lens = '0;
    lens[LOCAL] = 12'd6;
    lens[EAST] = 12'd6;
    lens[SOUTH] = 12'd6;
    driveFlits(5'b10100, 5'b10100, lens, 4'h5);
    driveFlits(5'b10101, 5'b00001, lens, 4'h5);
    driveFlits(5'b10101, 5'b00000, lens, 4'h5);
    repeat (3) driveFlits(5'b10001, 5'b00000, lens, 4'h6);  // east drops.
    repeat (3) driveFlits(5'b00001, 5'b00000, lens, 4'h7);  // south drops, wraps to local.
    repeat (3) driveFlits('0, '0, '0, 4'h0);
    randomTraffic(randomCycles);
    repeat (3) driveFlits('0, '0, '0, 4'h0);
    repeat (2) @(posedge clk);
    if (failed)
      $display("Errors found");
    else
      $display("No errors");
    $finish;
  end

endmodule

/* bench/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
  parameter int periodNs = 20,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;  // released on an edge, like the stimulus.
  end

endmodule

/* source/routerOutPort.sv */
`timescale 1ns/1ps

module routerOutPort #(
  parameter int dataWidth = 16  // at least lengthWidth.
) (
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::numPorts-1:0] req,
  input  routerPkg::flitKind flitType [routerPkg::numPorts],
  input  logic [dataWidth-1:0] flitData [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] grant,
  output logic outValid,
  output routerPkg::flitKind outType,
  output logic [dataWidth-1:0] outData,
  output routerPkg::portIdx outSource
);
  import routerPkg::*;

  logic [lengthWidth-1:0] portLength [numPorts];

  // packet length sits in the low bits of a header word.
  for (genvar p = 0; p < numPorts; p++)
  begin : gLength
    assign portLength[p] = flitData[p][lengthWidth-1:0];
  end

  portArbiter portArbiter_i (
    .clk(clk),
    .rst(rst),
    .req(req),
    .flitType(flitType),
    .length(portLength),
    .grant(grant)
  );

  outputMux #(
    .dataWidth(dataWidth)
  ) outputMux_i (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .req(req),
    .flitType(flitType),
    .flitData(flitData),
    .outValid(outValid),
    .outType(outType),
    .outData(outData),
    .outSource(outSource)
  );

endmodule

/* source/outputMux.sv */
`timescale 1ns/1ps

module outputMux #(
  parameter int dataWidth = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::numPorts-1:0] grant,
  input  logic [routerPkg::numPorts-1:0] req,
  input  routerPkg::flitKind flitType [routerPkg::numPorts],
  input  logic [dataWidth-1:0] flitData [routerPkg::numPorts],
  output logic outValid,
  output routerPkg::flitKind outType,
  output logic [dataWidth-1:0] outData,
  output routerPkg::portIdx outSource
);
  import routerPkg::*;

  portIdx selPort;
  logic selValid;

  // one-hot grant to port index.
  always_comb
  begin
    selPort = LOCAL;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        selPort = portIdx'(i);
    end
  end

  assign selValid = |(grant & req);  // granted port is still requesting.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outType <= IDLE;
      outData <= '0;
      outSource <= LOCAL;
    end
    else
    begin
      outValid <= selValid;
      if (selValid)
      begin
        outType <= flitType[selPort];
        outData <= flitData[selPort];
        outSource <= selPort;
      end
    end
  end

  // a flit only leaves for a port that held the grant.
  validNeedsGrant: assert property (
    @(posedge clk) disable iff (rst)
    $rose(outValid) |-> ($past(grant) != '0)
  )
    else $error("outputMux: outValid rose without a grant");

endmodule

/* source/portArbiter.sv */
`timescale 1ns/1ps

module portArbiter (
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::numPorts-1:0] req,
  input  routerPkg::flitKind flitType [routerPkg::numPorts],
  input  logic [routerPkg::lengthWidth-1:0] length [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] grant
);
  import routerPkg::*;

  logic [numPorts-1:0] nextGrant;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;
  logic idle;
  portIdx holder;

  // one hold timer per input port.
  for (genvar p = 0; p < numPorts; p++)
  begin : gTimer
    grantTimer grantTimer_i (
      .clk(clk),
      .rst(rst),
      .flitType(flitType[p]),
      .length(length[p]),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  assign idle = (grant == '0);

  // index of the current holder, don't care when idle.
  always_comb
  begin
    holder = LOCAL;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        holder = portIdx'(i);
    end
  end

  // Search order starts after the holder and skips it. From idle the
  // search starts after SOUTH, which gives fixed priority L, N, E, W, S.
  always_comb
  begin
    portIdx cand;
    logic found;
    nextGrant = '0;
    runTimer = '0;
    found = 1'b0;
    cand = idle ? SOUTH : holder;
    if (!idle && req[holder] && !timesUp[holder])
    begin
      nextGrant = grant;  // holder keeps the link.
      runTimer[holder] = 1'b1;
    end
    else
    begin
      for (int k = 0; k < numPorts; k++)
      begin
        cand = nextPort(cand);
        if (!found && req[cand] && (idle || cand != holder))
        begin
          nextGrant[cand] = 1'b1;
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= '0;
    else
      grant <= nextGrant;
  end

  // at most one port drives the output link.
  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  )
    else $error("portArbiter: grant is not one-hot");

  // the link is free right after reset.
  grantAfterReset: assert property (
    @(posedge clk)
    rst |=> (grant == '0)
  )
    else $error("portArbiter: grant set in the cycle after reset");

endmodule

/* source/grantTimer.sv */
`timescale 1ns/1ps

module grantTimer (
  input  logic clk,
  input  logic rst,
  input  routerPkg::flitKind flitType,
  input  logic [routerPkg::lengthWidth-1:0] length,
  input  logic runTimer,
  output logic timesUp
);
  import routerPkg::*;

  logic [lengthWidth-1:0] limit;  // hold cycles allowed for the packet.
  logic [lengthWidth-1:0] count;  // cycles held so far.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitType == HEAD)
        limit <= length;  // each header reloads the limit.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;  // restarts whenever the port is not holding.
    end
  end

  // expiry.
  assign timesUp = (count == limit);

  // the arbiter stops the timer at expiry, so the count cannot run past
  // the limit unless a new header shrinks the limit.
  countBound: assert property (
    @(posedge clk) disable iff (rst)
    (runTimer && count <= limit && flitType != HEAD) |=> (count <= limit)
  )
    else $error("grantTimer: count overran the latched limit");

endmodule

/* source/routerPkg.sv */
package routerPkg;

  localparam int numPorts = 5;
  localparam int lengthWidth = 12;  // packet length and hold count.
  localparam int flitTypeWidth = 3;

  // input ports of the router, also the rotation order.
  typedef enum logic [$clog2(numPorts)-1:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portIdx;

  typedef enum logic [flitTypeWidth-1:0] {
    IDLE = 3'd0,
    HEAD = 3'd1,  // carries the packet length.
    BODY = 3'd2,
    TAIL = 3'd3
  } flitKind;

  // rotation successor of a port.
  function automatic portIdx nextPort(input portIdx p);
    portIdx n;
    case (p)
      LOCAL: n = NORTH;
      NORTH: n = EAST;
      EAST:  n = WEST;
      WEST:  n = SOUTH;
      default: n = LOCAL;  // south wraps back to local.
    endcase
    return n;
  endfunction

endpackage
